//--- src/burst_writer.sv
module burst_writer
  import stream_dma_pkg::*;
  #(
    parameter int PTR_WIDTH = 10
  )
  (
    input  logic                 aclk,
    input  logic                 aresetn,

    // Control from the register block
    input  logic                 enable,
    input  logic [ADDR_W-1:0]    base,
    input  logic                 ptr_clear,
    output logic [PTR_WIDTH-1:0] ptr,

    // Data FIFO
    input  logic [DATA_W-1:0]    fifo_head,
    input  logic [LEVEL_W-1:0]   fifo_count,
    output logic                 fifo_pop,

    // Address queue
    output logic                 aw_push,
    output axi_aw_t              aw_entry,
    input  logic                 aw_queue_full,

    // Write-data channel
    output axi_w_t               w,
    output logic                 wvalid,
    input  logic                 wready
  );

  localparam int BEAT_W = $clog2(BURST_LEN);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_LEN - 1);

  logic [BEAT_W-1:0]    beat_cnt;
  logic [ID_W-1:0]      next_id;                   // Id of the next burst to issue
  logic [ID_W-1:0]      cur_id;                    // Id of the burst on the W channel
  logic                 clear_pending;

  logic                 beat_ok;
  logic                 last_beat;
  logic [PTR_WIDTH-1:0] ptr_inc;
  logic [PTR_WIDTH-1:0] start_ptr;
  logic                 level_ok;
  logic                 may_start;
  logic                 start;
  logic                 clear_now;

  assign beat_ok   = wvalid && wready;
  assign last_beat = beat_ok && (beat_cnt == LAST_BEAT);
  assign ptr_inc   = ptr + 1'b1;                   // Ring wraps at 2^PTR_WIDTH

  // Back to back, the word leaving on this edge is still counted
  assign level_ok = wvalid ? (fifo_count > LEVEL_W'(BURST_LEN))
                           : (fifo_count >= LEVEL_W'(BURST_LEN));

  // No start while a pointer clear waits to be applied
  assign may_start = enable && !ptr_clear && !clear_pending && !aw_queue_full;
  assign start     = may_start && level_ok && (!wvalid || last_beat);

  assign start_ptr = last_beat ? ptr_inc : ptr;    // Pointer after this edge

  assign clear_now = (ptr_clear || clear_pending) && (!wvalid || last_beat);

  // Address entry for the burst that starts on this edge
  assign aw_push       = start;
  assign aw_entry.id   = next_id;
  assign aw_entry.addr = base + (ADDR_W'(start_ptr) << BEAT_SHIFT);
  assign aw_entry.len  = LEN_W'(BURST_LEN - 1);

  // Data beats come straight off the FIFO head
  assign w.id     = cur_id;
  assign w.data   = fifo_head;
  assign w.last   = (beat_cnt == LAST_BEAT);
  assign fifo_pop = beat_ok;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wvalid        <= 1'b0;
      beat_cnt      <= '0;
      next_id       <= '0;
      cur_id        <= '0;
      ptr           <= '0;
      clear_pending <= 1'b0;
    end
    else
    begin
      if (start)
        wvalid <= 1'b1;
      else if (last_beat)
        wvalid <= 1'b0;

      if (beat_ok)
        beat_cnt <= beat_cnt + 1'b1;               // Back to 0 after the last beat

      if (start)
      begin
        cur_id  <= next_id;
        next_id <= next_id + 1'b1;                 // Modulo 16
      end

      if (clear_now)
        ptr <= '0;
      else if (beat_ok)
        ptr <= ptr_inc;

      // Held over a running burst, applied once it ends
      clear_pending <= (clear_pending || ptr_clear) && !clear_now;
    end
  end

endmodule

//--- src/dma_ctrl_regs.sv
module dma_ctrl_regs
  import stream_dma_pkg::*;
  #(
    parameter int PTR_WIDTH = 10
  )
  (
    input  logic                  aclk,
    input  logic                  aresetn,

    // Register bus
    input  cfg_req_t              cfg_req,
    input  logic                  cfg_valid,
    output logic [CFG_DATA_W-1:0] cfg_rdata,
    output logic                  cfg_rvalid,

    // Burst writer control and status
    output logic                  enable,
    output logic [ADDR_W-1:0]     base,
    output logic                  ptr_clear,
    input  logic [PTR_WIDTH-1:0]  ptr,

    // Write responses
    input  logic                  bvalid
  );

  logic [CFG_DATA_W-1:0] bresp_count;
  logic                  wr_req;
  logic                  rd_req;

  assign wr_req = cfg_valid && cfg_req.write;
  assign rd_req = cfg_valid && !cfg_req.write;

  // Control registers and response counter
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      enable      <= 1'b0;
      base        <= '0;
      ptr_clear   <= 1'b0;
      bresp_count <= '0;
    end
    else
    begin
      ptr_clear <= wr_req && (cfg_req.addr == REG_CTRL);  // Any CTRL write

      if (wr_req)
      begin
        case (cfg_req.addr)
          REG_CTRL: enable <= cfg_req.data[0];
          REG_BASE: base   <= cfg_req.data;
          default:  ;                              // PTR and BRESP are read only
        endcase
      end

      if (bvalid)
        bresp_count <= bresp_count + 1'b1;         // Wraps at 2^32
    end
  end

  // Read return, one cycle after the request
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      cfg_rvalid <= 1'b0;
    else
      cfg_rvalid <= rd_req;
  end

  always_ff @(posedge aclk)
  begin
    if (rd_req)
    begin
      case (cfg_req.addr)
        REG_CTRL:  cfg_rdata <= {{(CFG_DATA_W-1){1'b0}}, enable};
        REG_BASE:  cfg_rdata <= base;
        REG_PTR:   cfg_rdata <= CFG_DATA_W'(ptr);
        REG_BRESP: cfg_rdata <= bresp_count;
        default:   cfg_rdata <= '0;
      endcase
    end
  end

endmodule

//--- src/stream_dma_pkg.sv
package stream_dma_pkg;

  localparam int DATA_W     = 64;                  // Stream word and write beat
  localparam int ADDR_W     = 32;                  // AXI byte address
  localparam int ID_W       = 4;                   // Transaction id
  localparam int BURST_LEN  = 16;                  // Beats per burst
  localparam int BEAT_SHIFT = 3;                   // log2 of bytes per beat
  localparam int LEN_W      = 4;                   // AXI3 length field

  // The writer sees the fill level clipped to this width
  localparam int LEVEL_W    = $clog2(2 * BURST_LEN);

  localparam int CFG_ADDR_W = 4;                   // Register word address
  localparam int CFG_DATA_W = 32;                  // Register data

  // Write-address entry, 40 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;                        // Beat count minus one
  } axi_aw_t;

  // Write-data beat, 69 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic              last;
  } axi_w_t;

  // Register request, 37 bits
  typedef struct packed {
    logic                  write;
    logic [CFG_ADDR_W-1:0] addr;
    logic [CFG_DATA_W-1:0] data;
  } cfg_req_t;

  // Register map
  localparam logic [CFG_ADDR_W-1:0] REG_CTRL  = 4'd0;  // Bit 0 enable
  localparam logic [CFG_ADDR_W-1:0] REG_BASE  = 4'd1;  // Base byte address
  localparam logic [CFG_ADDR_W-1:0] REG_PTR   = 4'd2;  // Word pointer, read only
  localparam logic [CFG_ADDR_W-1:0] REG_BRESP = 4'd3;  // Response count, read only

endpackage

//--- src/stream_dma_top.sv
module stream_dma_top
  import stream_dma_pkg::*;
  #(
    parameter int PTR_WIDTH  = 10,
    parameter int FIFO_DEPTH = 64                  // At least 2 * BURST_LEN
  )
  (
    input  logic                  aclk,
    input  logic                  aresetn,

    // Stream input
    input  logic [DATA_W-1:0]     s_tdata,
    input  logic                  s_tvalid,
    output logic                  s_tready,

    // Register bus
    input  cfg_req_t              cfg_req,
    input  logic                  cfg_valid,
    output logic [CFG_DATA_W-1:0] cfg_rdata,
    output logic                  cfg_rvalid,

    // AXI write channels
    output axi_aw_t               aw,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_w_t                w,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid
  );

  localparam int AW_QUEUE_DEPTH = 4;
  localparam int CNT_W          = $clog2(FIFO_DEPTH + 1);
  localparam int LEVEL_MAX      = 2**LEVEL_W - 1;

  logic [DATA_W-1:0]    data_head;
  logic [CNT_W-1:0]     data_count;
  logic                 data_full;
  logic                 data_pop;
  logic [LEVEL_W-1:0]   writer_level;

  logic                 aw_push;
  axi_aw_t              aw_entry;
  logic                 aw_full;

  logic                 enable;
  logic [ADDR_W-1:0]    base;
  logic                 ptr_clear;
  logic [PTR_WIDTH-1:0] ptr;

  assign s_tready = !data_full;

  // Writer only needs to tell a burst from a burst plus one word
  assign writer_level = (data_count > CNT_W'(LEVEL_MAX)) ? LEVEL_W'(LEVEL_MAX)
                                                         : LEVEL_W'(data_count);

  stream_fifo #(.payload_t(logic [DATA_W-1:0]), .DEPTH(FIFO_DEPTH)) u_data_fifo (
    .aclk(aclk), .aresetn(aresetn),
    .push(s_tvalid && s_tready), .push_data(s_tdata),
    .pop(data_pop), .head(data_head),
    .nonempty(), .full(data_full), .count(data_count)
  );

  stream_fifo #(.payload_t(axi_aw_t), .DEPTH(AW_QUEUE_DEPTH)) u_aw_queue (
    .aclk(aclk), .aresetn(aresetn),
    .push(aw_push), .push_data(aw_entry),
    .pop(awvalid && awready), .head(aw),
    .nonempty(awvalid), .full(aw_full), .count()
  );

  burst_writer #(.PTR_WIDTH(PTR_WIDTH)) u_writer (
    .aclk(aclk), .aresetn(aresetn),
    .enable(enable), .base(base), .ptr_clear(ptr_clear), .ptr(ptr),
    .fifo_head(data_head), .fifo_count(writer_level), .fifo_pop(data_pop),
    .aw_push(aw_push), .aw_entry(aw_entry), .aw_queue_full(aw_full),
    .w(w), .wvalid(wvalid), .wready(wready)
  );

  dma_ctrl_regs #(.PTR_WIDTH(PTR_WIDTH)) u_regs (
    .aclk(aclk), .aresetn(aresetn),
    .cfg_req(cfg_req), .cfg_valid(cfg_valid),
    .cfg_rdata(cfg_rdata), .cfg_rvalid(cfg_rvalid),
    .enable(enable), .base(base), .ptr_clear(ptr_clear), .ptr(ptr),
    .bvalid(bvalid)
  );

endmodule

//--- src/stream_fifo.sv
module stream_fifo
  #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16                   // At least 2
  )
  (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         push,
    input  payload_t                     push_data,
    input  logic                         pop,
    output payload_t                     head,
    output logic                         nonempty,
    output logic                         full,
    output logic [$clog2(DEPTH+1)-1:0]   count
  );

  localparam int IDX_W = $clog2(DEPTH);

  payload_t         mem [DEPTH];
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             do_push;
  logic             do_pop;

  function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
    if (idx == IDX_W'(DEPTH - 1))
      return '0;                                   // Wrap for any depth
    return idx + 1'b1;
  endfunction

  assign do_push = push && !full;                  // Push into a full buffer is lost
  assign do_pop  = pop && nonempty;

  assign head     = mem[rd_idx];                   // Oldest entry, no read latency
  assign nonempty = (count != '0);
  assign full     = (count == ($clog2(DEPTH+1))'(DEPTH));

  always_ff @(posedge aclk)
  begin
    if (do_push)
      mem[wr_idx] <= push_data;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_idx <= '0;
      rd_idx <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_idx <= next_idx(wr_idx);
      if (do_pop)
        rd_idx <= next_idx(rd_idx);

      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                   // Both or neither
      endcase
    end
  end

endmodule

//--- stream_dma.f
src/stream_dma_pkg.sv
src/stream_fifo.sv
src/dma_ctrl_regs.sv
src/burst_writer.sv
src/stream_dma_top.sv
verification/axi_mem_model.sv
verification/tb_stream_dma.sv

//--- verification/axi_mem_model.sv
module axi_mem_model
  import stream_dma_pkg::*;
  (
    input  logic    aclk,
    input  logic    aresetn,
    input  logic    stall_en,                      // Random ready stalls
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output logic    bvalid,
    output int      bursts_stored,
    output int      error_count
  );

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 1024;

  logic [DATA_W-1:0] mem [MEM_WORDS];              // One entry per 8-byte beat
  logic [ID_W-1:0]   id_log [64];                  // Id of each stored burst
  axi_aw_t           aw_q [$];
  axi_w_t            w_q [$];
  int                beat_idx;
  logic [15:0]       lfsr;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  initial
  begin
    awready = 1'b0;                                // Bus is quiet until the first edge
    wready  = 1'b0;
    bvalid  = 1'b0;
  end

  always @(posedge aclk)
  begin
    axi_aw_t entry;
    axi_w_t  beat;
    int      errs;
    errs = 0;
    if (!aresetn)
    begin
      awready       <= 1'b0;
      wready        <= 1'b0;
      bvalid        <= 1'b0;
      bursts_stored <= 0;
      error_count   <= 0;
      beat_idx = 0;
      lfsr = 16'd10811;
      aw_q.delete();
      w_q.delete();
    end
    else
    begin
      if (stall_en)
      begin
        lfsr = lfsr_next(lfsr);
        awready <= lfsr[0];
        lfsr = lfsr_next(lfsr);
        wready <= lfsr[0];
      end
      else
      begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
      if (awvalid && awready)
      begin
        if (aw.len != LEN_W'(BURST_LEN - 1))
        begin
          $display("Address entry with id %0d has length field %0d, not 15", aw.id, aw.len);
          errs++;
        end
        aw_q.push_back(aw);
      end
      if (wvalid && wready)
      begin
        if (w.last != (beat_idx == BURST_LEN - 1))
        begin
          $display("Last flag is %0b on beat %0d of a burst", w.last, beat_idx);
          errs++;
        end
        w_q.push_back(w);
        beat_idx = (beat_idx + 1) % BURST_LEN;
      end
      bvalid <= wvalid && wready && w.last;        // Response right after the last beat

      // Address and data may arrive in either order
      if (aw_q.size() > 0 && w_q.size() >= BURST_LEN)
      begin
        entry = aw_q.pop_front();
        id_log[bursts_stored % 64] <= entry.id;
        bursts_stored <= bursts_stored + 1;
        for (int i = 0; i < BURST_LEN; i++)
        begin
          beat = w_q.pop_front();
          if (beat.id != entry.id)
          begin
            $display("Data beat id %0d does not match address id %0d", beat.id, entry.id);
            errs++;
          end
          mem[((entry.addr >> BEAT_SHIFT) + i) % MEM_WORDS] <= beat.data;
        end
      end
      error_count <= error_count + errs;
    end
  end

endmodule

//--- verification/tb_stream_dma.sv
module tb_stream_dma
  import stream_dma_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int                PTR_W       = 6;
  localparam int                RING        = 2**PTR_W;        // Words in the ring
  localparam logic [ADDR_W-1:0] BASE        = 32'h1000;
  localparam int                BASE_IDX    = BASE >> BEAT_SHIFT;
  localparam int                TOTAL_WORDS = 160;             // Words sent over all tests
  localparam int                WAIT_LIMIT  = 3000;

  logic                  aclk;
  logic                  aresetn;
  logic [DATA_W-1:0]     s_tdata;
  logic                  s_tvalid;
  logic                  s_tready;
  cfg_req_t              cfg_req;
  logic                  cfg_valid;
  logic [CFG_DATA_W-1:0] cfg_rdata;
  logic                  cfg_rvalid;
  axi_aw_t               aw;
  logic                  awvalid;
  logic                  awready;
  axi_w_t                w;
  logic                  wvalid;
  logic                  wready;
  logic                  bvalid;
  logic                  stall_en;
  int                    bursts_stored;
  int                    model_errors;

  logic [DATA_W-1:0]     sent [$];                 // Words of the current test, in order
  logic [15:0]           lfsr;
  int                    errors = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;
  int                    bursts = 0;               // Bursts expected so far
  int                    exp_ptr = 0;
  int                    b_seen = 0;

  stream_dma_top #(.PTR_WIDTH(PTR_W)) dut (
    .aclk(aclk), .aresetn(aresetn),
    .s_tdata(s_tdata), .s_tvalid(s_tvalid), .s_tready(s_tready),
    .cfg_req(cfg_req), .cfg_valid(cfg_valid), .cfg_rdata(cfg_rdata), .cfg_rvalid(cfg_rvalid),
    .aw(aw), .awvalid(awvalid), .awready(awready),
    .w(w), .wvalid(wvalid), .wready(wready), .bvalid(bvalid)
  );

  axi_mem_model mem_model (
    .aclk(aclk), .aresetn(aresetn), .stall_en(stall_en),
    .aw(aw), .awvalid(awvalid), .awready(awready),
    .w(w), .wvalid(wvalid), .wready(wready), .bvalid(bvalid),
    .bursts_stored(bursts_stored), .error_count(model_errors)
  );

  initial
  begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  always @(posedge aclk)
  begin
    if (!aresetn)
      b_seen <= 0;
    else if (bvalid)
      b_seen <= b_seen + 1;
  end

  function automatic logic take_bit();
    lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    return lfsr[0];
  endfunction

  function automatic logic [DATA_W-1:0] random_word();
    logic [DATA_W-1:0] word;
    for (int i = 0; i < DATA_W; i++)
      word[i] = take_bit();
    return word;
  endfunction

  function automatic int error_total();
    return errors + model_errors;
  endfunction

  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [CFG_DATA_W-1:0] data);
    @(posedge aclk);
    cfg_req   <= {1'b1, addr, data};
    cfg_valid <= 1'b1;
    @(posedge aclk);
    cfg_valid <= 1'b0;
  endtask

  task automatic expect_reg(input logic [CFG_ADDR_W-1:0] addr,
                            input logic [CFG_DATA_W-1:0] exp, input string name);
    @(posedge aclk);
    cfg_req   <= {1'b0, addr, 32'h0};
    cfg_valid <= 1'b1;
    @(posedge aclk);
    cfg_valid <= 1'b0;
    @(negedge aclk);                               // Read data is due one cycle later
    if (!cfg_rvalid)
    begin
      $display("Read of %s came back without cfg_rvalid", name);
      errors++;
    end
    else if (cfg_rdata !== exp)
    begin
      $display("Fail %s expected %h got %h", name, exp, cfg_rdata);
      errors++;
    end
  endtask

  task automatic send_words(input int n, input logic pauses);
    logic [DATA_W-1:0] word;
    for (int i = 0; i < n; i++)
    begin
      word = random_word();
      if (pauses && take_bit())
      begin
        @(posedge aclk);
        s_tvalid <= 1'b0;                          // Idle cycle in the stream
      end
      @(posedge aclk);
      s_tdata  <= word;
      s_tvalid <= 1'b1;
      @(negedge aclk);
      while (!s_tready)
        @(negedge aclk);
      sent.push_back(word);                        // Taken on the next edge
    end
    @(posedge aclk);
    s_tvalid <= 1'b0;
  endtask

  task automatic expect_no_burst(input int cycles);
    int seen;
    seen = 0;
    repeat (cycles)
    begin
      @(negedge aclk);
      if (awvalid || wvalid)
        seen = 1;
    end
    if (seen)
    begin
      $display("A burst started although it should not have");
      errors++;
    end
  endtask

  task automatic wait_bursts(input int target);
    int cycles;
    cycles = 0;
    @(negedge aclk);
    while ((bursts_stored < target || b_seen < target) && cycles < WAIT_LIMIT)
    begin
      @(negedge aclk);
      cycles++;
    end
    if (cycles >= WAIT_LIMIT)
    begin
      $display("Timed out waiting for burst %0d to complete", target);
      errors++;
    end
  endtask

  // Words land in the ring from exp_ptr on, bursts carry consecutive ids
  task automatic finish_bursts();
    int n;
    int idx;
    n = sent.size() / BURST_LEN;
    wait_bursts(bursts + n);
    for (int i = 0; i < sent.size(); i++)
    begin
      idx = BASE_IDX + (exp_ptr + i) % RING;
      if (mem_model.mem[idx] !== sent[i])
      begin
        $display("Fail mem[%h] expected %h got %h", idx << BEAT_SHIFT, sent[i], mem_model.mem[idx]);
        errors++;
      end
    end
    for (int k = bursts; k < bursts + n; k++)
    begin
      if (mem_model.id_log[k] !== ID_W'(k))
      begin
        $display("Fail aw.id expected %h got %h", ID_W'(k), mem_model.id_log[k]);
        errors++;
      end
    end
    bursts += n;
    exp_ptr = (exp_ptr + sent.size()) % RING;
    expect_reg(REG_PTR, exp_ptr, "cfg_rdata (REG_PTR)");
    expect_reg(REG_BRESP, bursts, "cfg_rdata (REG_BRESP)");
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (error_total() == err_before)
      $display("Test %s passed", name);
    else
    begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, error_total() - err_before);
    end
  endtask

  task automatic test_reset();
    int err0;
    err0 = error_total();
    @(negedge aclk);
    if (awvalid !== 1'b0 || wvalid !== 1'b0)
    begin
      $display("Fail awvalid/wvalid expected 0/0 got %h/%h", awvalid, wvalid);
      errors++;
    end
    if (s_tready !== 1'b1)
    begin
      $display("Fail s_tready expected 1 got %h", s_tready);
      errors++;
    end
    expect_reg(REG_PTR, 0, "cfg_rdata (REG_PTR)");
    expect_reg(REG_BRESP, 0, "cfg_rdata (REG_BRESP)");
    report_test("reset", err0);
  endtask

  task automatic test_single_burst();
    int err0;
    err0 = error_total();
    cfg_write(REG_BASE, BASE);
    cfg_write(REG_CTRL, 32'h1);
    sent.delete();
    send_words(16, 1'b0);
    finish_bursts();
    report_test("single burst", err0);
  endtask

  task automatic test_threshold();
    int err0;
    err0 = error_total();
    sent.delete();
    send_words(10, 1'b0);
    expect_no_burst(100);                          // Ten words are not enough
    send_words(6, 1'b0);
    finish_bursts();
    report_test("threshold", err0);
  endtask

  task automatic test_backpressure();
    int err0;
    err0 = error_total();
    @(posedge aclk);
    stall_en <= 1'b1;
    sent.delete();
    send_words(48, 1'b1);
    finish_bursts();
    @(posedge aclk);
    stall_en <= 1'b0;
    report_test("back-pressure", err0);
  endtask

  task automatic test_ring_wrap();
    int err0;
    err0 = error_total();
    sent.delete();
    send_words(64, 1'b0);                          // A full turn, last burst at base
    finish_bursts();
    report_test("ring wrap", err0);
  endtask

  task automatic test_disable_clear();
    int err0;
    err0 = error_total();
    cfg_write(REG_CTRL, 32'h0);
    exp_ptr = 0;                                   // Writing CTRL clears the pointer
    sent.delete();
    send_words(16, 1'b0);
    expect_no_burst(100);
    expect_reg(REG_PTR, 0, "cfg_rdata (REG_PTR)");
    cfg_write(REG_CTRL, 32'h1);
    finish_bursts();
    report_test("disable and clear", err0);
  endtask

  initial
  begin
    aresetn   = 1'b0;
    s_tdata   = '0;
    s_tvalid  = 1'b0;
    cfg_req   = '0;
    cfg_valid = 1'b0;
    stall_en  = 1'b0;
    lfsr      = 16'd10811;
    repeat (5) @(posedge aclk);
    aresetn <= 1'b1;
    test_reset();
    test_single_burst();
    test_threshold();
    test_backpressure();
    test_ring_wrap();
    test_disable_clear();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total());
    if (error_total() == 0 && tests_failed == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    repeat (200 * TOTAL_WORDS + 2000) @(posedge aclk);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule
